//--- common/ip1_pkg.sv
`default_nettype none

package ip1_pkg;

  // ------------------------------
  // Plain vector types
  // ------------------------------
  typedef logic [6:0]   cfg_period_t;   // Count of fw_axi_clk cycles
  typedef logic [7:0]   sw_addr_t;      // Word address, argument bits 23..16
  typedef logic [15:0]  cfg_word_t;     // One configuration array word
  typedef logic [31:0]  read_word_t;    // Software read data / status
  typedef logic [255:0] chain_t;        // Config image and readback image
  typedef logic [8:0]   chain_cnt_t;    // Shift count, 0..256

  // ------------------------------
  // Sizes and constants
  // ------------------------------
  localparam int CFG_WORDS     = 16;                  // Configuration array depth
  localparam int CFG_ADDR_BITS = $clog2(CFG_WORDS);
  localparam int CHAIN_BITS    = 256;                 // Shift chain length
  localparam int CAP_WORDS     = 8;                   // Readback words of 32 bits
  localparam int CAP_ADDR_BITS = $clog2(CAP_WORDS);
  localparam int ADDR_MSB      = 23;                  // Address field in the argument word
  localparam int ADDR_LSB      = 16;

  localparam logic [3:0]  TEST1_NUMBER = 4'd1;
  localparam cfg_period_t MIN_DELAY    = 7'd3;        // Shortest usable shift delay

  // Status word bit positions
  localparam int ST_RESET      = 0;
  localparam int ST_W_STATIC   = 1;
  localparam int ST_R_STATIC   = 2;
  localparam int ST_W_ARRAY    = 3;
  localparam int ST_R_ARRAY    = 4;
  localparam int ST_R_DATA     = 5;
  localparam int ST_EXECUTE    = 6;
  localparam int ST_TEST1_DONE = 12;
  localparam int ST_CFG_ERROR  = 31;

  // ------------------------------
  // Structs
  // ------------------------------
  // Single-cycle strobes from software
  typedef struct packed {
    logic w_cfg_static;
    logic r_cfg_static;
    logic w_cfg_array;
    logic r_cfg_array;
    logic r_data_array;
    logic w_status_clear;
    logic w_execute;
  } op_code_t;

  typedef struct packed {
    logic [15:0] spare;
    logic        super_pixel_sel;
    cfg_period_t fast_period;         // Bits 6..0
  } static_cfg_t;

  // Execute word, laid over sw_write24_0
  typedef struct packed {
    logic        mask_reset_not;      // Bit 23, keeps reset_not high
    logic [3:0]  spare;
    logic        loopback;            // Bit 18
    logic [3:0]  test_number;
    cfg_period_t sample;              // Readback sample phase
    cfg_period_t delay;               // Shift phase, bits 6..0
  } test_cfg_t;

  // Pins toward the ASIC
  typedef struct packed {
    logic super_pixel_sel;
    logic config_clk;
    logic reset_not;
    logic config_in;
    logic config_load;
  } asic_out_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    RESET_PULSE,
    SHIFT,
    DONE
  } test1_state_t;

endpackage

`default_nettype wire

//--- configclk/configclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module configclk_gen #(
  parameter int CNT_WIDTH = 7
) (
  input  wire                  fw_axi_clk,
  input  wire                  op_code_w_reset,
  input  wire                  enable,
  input  wire  [CNT_WIDTH-1:0] configclk_period,   // Last counter value of a cycle
  output logic [CNT_WIDTH-1:0] clk_counter,        // Phase seen by the FSM
  output logic                 configclk
);

  logic [CNT_WIDTH-1:0] cnt_nxt;

  // Count 0..period inclusive, then wrap
  always_comb begin
    if (clk_counter >= configclk_period) begin
      cnt_nxt = '0;
    end else begin
      cnt_nxt = clk_counter + 1'b1;
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      clk_counter <= '0;
      configclk   <= 1'b0;
    end else if (enable) begin
      clk_counter <= cnt_nxt;
      configclk   <= (cnt_nxt > (configclk_period >> 1));  // High in upper half of the count
    end
  end

endmodule

`default_nettype wire

//--- test1/config_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module config_shifter (
  input  wire                  fw_axi_clk,
  input  wire                  chain_load,
  input  wire                  chain_shift,
  input  wire ip1_pkg::chain_t cfg_array,     // Image from the configuration array
  output logic                 chain_bit0,
  output logic                 chain_last
);

  import ip1_pkg::*;

  chain_t     chain_q;                        // Outgoing image, bit 0 goes first
  chain_cnt_t shift_cnt;                      // Shifts done since load

  always_ff @(posedge fw_axi_clk) begin
    if (chain_load) begin
      chain_q   <= cfg_array;
      shift_cnt <= '0;
    end else if (chain_shift) begin
      chain_q   <= {1'b0, chain_q[CHAIN_BITS-1:1]};      // Shift right
      shift_cnt <= shift_cnt + 1'b1;
    end
  end

  assign chain_bit0 = chain_q[0];
  assign chain_last = (shift_cnt == chain_cnt_t'(CHAIN_BITS - 1));  // 256th shift pending

endmodule

`default_nettype wire

//--- test1/readback_capture.sv
`timescale 1ns/1ps
`default_nettype none

module readback_capture (
  input  wire             fw_axi_clk,
  input  wire             op_code_w_reset,
  input  wire             capture_strobe,     // One per config-clock cycle in SHIFT
  input  wire             loopback,
  input  wire             config_in,          // Bit being sent to the ASIC
  input  wire             fw_config_out,      // Bit coming back from the ASIC
  output ip1_pkg::chain_t capture
);

  import ip1_pkg::*;

  logic bit_in;

  assign bit_in = loopback ? config_in : fw_config_out;

  // New bit enters at the top, first bit ends in bit 0
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      capture <= '0;
    end else if (capture_strobe) begin
      capture <= {bit_in, capture[CHAIN_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

//--- test1/test1_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module test1_fsm (
  input  wire                       fw_axi_clk,
  input  wire                       op_code_w_reset,
  input  wire ip1_pkg::op_code_t    op_en,
  input  wire [23:0]                sw_write24_0,
  input  wire ip1_pkg::static_cfg_t static_cfg,
  input  wire ip1_pkg::cfg_period_t clk_counter,
  input  wire                       configclk,
  input  wire                       chain_bit0,      // Current outgoing bit
  input  wire                       chain_last,      // Next shift ends the chain
  output logic                      chain_load,
  output logic                      chain_shift,
  output logic                      capture_strobe,
  output logic                      loopback,
  output ip1_pkg::asic_out_t        asic_out,
  output logic                      test1_done,
  output logic                      cfg_error
);

  import ip1_pkg::*;

  test_cfg_t    exec_cfg;              // Argument seen as an execute word
  test_cfg_t    test_cfg;              // Latched on w_execute
  logic         test1_en;
  test1_state_t state;
  test1_state_t state_nxt;

  assign exec_cfg = test_cfg_t'(sw_write24_0);

  // ------------------------------
  // Execute latch and state
  // ------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      test_cfg  <= '0;
      test1_en  <= 1'b0;
      cfg_error <= 1'b0;
      state     <= IDLE;
    end else if (op_en.w_execute) begin
      test_cfg  <= exec_cfg;
      test1_en  <= (exec_cfg.test_number == TEST1_NUMBER);
      // Delay must fit inside one config-clock cycle
      cfg_error <= (exec_cfg.delay < MIN_DELAY) ||
                   (exec_cfg.delay > static_cfg.fast_period);
      state     <= IDLE;                                      // Any execute restarts
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (test1_en) begin
          state_nxt = LOAD;
        end
      end
      LOAD: state_nxt = RESET_PULSE;                          // Chain loads here
      RESET_PULSE: begin
        if (clk_counter == static_cfg.fast_period) begin
          state_nxt = SHIFT;                                  // SHIFT opens at counter 0
        end
      end
      SHIFT: begin
        if (chain_shift && chain_last) begin
          state_nxt = DONE;
        end
      end
      DONE: state_nxt = DONE;                                 // Held until execute or reset
      default: state_nxt = IDLE;
    endcase
  end

  // ------------------------------
  // Chain and readback control
  // ------------------------------
  assign chain_load     = (state == LOAD);
  assign chain_shift    = (state == SHIFT) && (clk_counter == test_cfg.delay);
  assign capture_strobe = (state == SHIFT) && (clk_counter == test_cfg.sample);
  assign loopback       = test_cfg.loopback;
  assign test1_done     = (state == DONE);

  // ASIC pins, all low unless test1 is selected
  always_comb begin
    asic_out = '0;
    if (test1_en) begin
      asic_out.super_pixel_sel = static_cfg.super_pixel_sel;
      asic_out.config_clk      = (state == SHIFT) && configclk;
      asic_out.reset_not       = !((state == RESET_PULSE) && !test_cfg.mask_reset_not);
      asic_out.config_in       = (state == SHIFT) && chain_bit0;
      asic_out.config_load     = (state != SHIFT);            // Low only while shifting
    end
  end

endmodule

`default_nettype wire

//--- design/sw_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sw_cmd_regs (
  input  wire                    fw_axi_clk,
  input  wire                    op_code_w_reset,
  input  wire                    fw_dev_id_enable,
  input  wire ip1_pkg::op_code_t op_code,
  input  wire [23:0]             sw_write24_0,
  output ip1_pkg::op_code_t      op_en,          // Gated strobes for all other blocks
  output ip1_pkg::static_cfg_t   static_cfg,
  output ip1_pkg::chain_t        cfg_array       // Word 0 in low bits
);

  import ip1_pkg::*;

  sw_addr_t                  addr;             // Word address from the argument
  logic                      addr_ok;          // Address inside the array
  cfg_word_t [CFG_WORDS-1:0] cfg_mem;          // 16 x 16 configuration words

  // ------------------------------
  // Strobe gating
  // ------------------------------
  // Only place where the device enable is tested
  assign op_en = fw_dev_id_enable ? op_code : '0;

  assign addr      = sw_write24_0[ADDR_MSB:ADDR_LSB];
  assign addr_ok   = (addr < sw_addr_t'(CFG_WORDS));  // 16 and up ignored
  assign cfg_array = cfg_mem;                          // Packed words form the chain image

  // ------------------------------
  // Static register and array
  // ------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_cfg <= '0;
      cfg_mem    <= '0;
    end else begin
      if (op_en.w_cfg_static) begin
        static_cfg <= static_cfg_t'(sw_write24_0);    // Whole 24-bit word
      end
      if (op_en.w_cfg_array && addr_ok) begin
        // Low half of the argument is the data
        cfg_mem[addr[CFG_ADDR_BITS-1:0]] <= sw_write24_0[$bits(cfg_word_t)-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sw_readout.sv
`timescale 1ns/1ps
`default_nettype none

module sw_readout (
  input  wire                      fw_axi_clk,
  input  wire                      op_code_w_reset,
  input  wire ip1_pkg::op_code_t   op_en,
  input  wire [23:0]               sw_write24_0,
  input  wire ip1_pkg::static_cfg_t static_cfg,
  input  wire ip1_pkg::chain_t     cfg_array,
  input  wire ip1_pkg::chain_t     capture,         // Readback image, bit 0 first captured
  input  wire                      test1_done,
  input  wire                      cfg_error,
  output ip1_pkg::read_word_t      fw_read_data32,  // Combinational, same cycle as strobe
  output ip1_pkg::read_word_t      fw_read_status32
);

  import ip1_pkg::*;

  sw_addr_t                   addr;
  logic [CFG_ADDR_BITS-1:0]   word_a;          // Requested word
  logic [CFG_ADDR_BITS-1:0]   word_b;          // Its neighbor, wraps 15 to 0
  cfg_word_t  [CFG_WORDS-1:0] cfg_words;
  read_word_t [CAP_WORDS-1:0] cap_words;
  read_word_t                 status_q;

  assign addr      = sw_write24_0[ADDR_MSB:ADDR_LSB];
  assign word_a    = addr[CFG_ADDR_BITS-1:0];
  assign word_b    = word_a + 1'b1;
  assign cfg_words = cfg_array;
  assign cap_words = capture;

  // ------------------------------
  // Read-data multiplexer
  // ------------------------------
  always_comb begin
    fw_read_data32 = '0;                                     // No strobe reads zero
    if (op_en.r_cfg_static) begin
      fw_read_data32 = {8'h00, static_cfg};                  // Zero-extended
    end else if (op_en.r_cfg_array) begin
      if (addr < sw_addr_t'(CFG_WORDS)) begin
        fw_read_data32 = {cfg_words[word_b], cfg_words[word_a]};  // Pair read
      end
    end else if (op_en.r_data_array) begin
      if (addr < sw_addr_t'(CAP_WORDS)) begin
        fw_read_data32 = cap_words[addr[CAP_ADDR_BITS-1:0]];
      end
    end
  end

  // ------------------------------
  // Sticky status word
  // ------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_en.w_status_clear) begin
      status_q <= '0;                                        // Clear beats everything
    end else if (op_code_w_reset) begin
      status_q           <= '0;
      status_q[ST_RESET] <= 1'b1;
    end else begin
      if (op_en.w_cfg_static) begin
        status_q[ST_W_STATIC] <= 1'b1;
      end
      if (op_en.r_cfg_static) begin
        status_q[ST_R_STATIC] <= 1'b1;
      end
      if (op_en.w_cfg_array) begin
        status_q[ST_W_ARRAY] <= 1'b1;
      end
      if (op_en.r_cfg_array) begin
        status_q[ST_R_ARRAY] <= 1'b1;
      end
      if (op_en.r_data_array) begin
        status_q[ST_R_DATA] <= 1'b1;
      end
      if (op_en.w_execute) begin
        status_q[ST_EXECUTE] <= 1'b1;
      end
      status_q[ST_TEST1_DONE] <= test1_done;                 // Live flags, one cycle late
      status_q[ST_CFG_ERROR]  <= cfg_error;
    end
  end

  assign fw_read_status32 = status_q;

endmodule

`default_nettype wire

//--- design/ip1_top.sv
`timescale 1ns/1ps
`default_nettype none

module ip1_top (
  input  wire                fw_axi_clk,
  input  wire                op_code_w_reset,      // Synchronous, active high
  input  wire                fw_dev_id_enable,
  input  wire ip1_pkg::op_code_t op_code,          // Single-cycle strobes
  input  wire [23:0]         sw_write24_0,         // Argument word
  output ip1_pkg::read_word_t fw_read_data32,
  output ip1_pkg::read_word_t fw_read_status32,
  output ip1_pkg::asic_out_t asic_out,
  input  wire                fw_config_out          // Serial data back from the ASIC
);

  import ip1_pkg::*;

  // ------------------------------
  // Internal wires
  // ------------------------------
  op_code_t    op_en;                  // Strobes gated with device enable
  static_cfg_t static_cfg;
  chain_t      cfg_array;              // Word 0 in low bits
  chain_t      capture;                // Readback image
  cfg_period_t clk_counter;            // Config-clock phase
  logic        configclk;
  logic        chain_bit0;
  logic        chain_last;             // Next shift is the 256th
  logic        chain_load;
  logic        chain_shift;
  logic        capture_strobe;
  logic        loopback;
  logic        test1_done;
  logic        cfg_error;

  sw_cmd_regs u_cmd (
    .fw_axi_clk       (fw_axi_clk),
    .op_code_w_reset  (op_code_w_reset),
    .fw_dev_id_enable (fw_dev_id_enable),
    .op_code          (op_code),
    .sw_write24_0     (sw_write24_0),
    .op_en            (op_en),
    .static_cfg       (static_cfg),
    .cfg_array        (cfg_array)
  );

  sw_readout u_readout (
    .fw_axi_clk       (fw_axi_clk),
    .op_code_w_reset  (op_code_w_reset),
    .op_en            (op_en),
    .sw_write24_0     (sw_write24_0),
    .static_cfg       (static_cfg),
    .cfg_array        (cfg_array),
    .capture          (capture),
    .test1_done       (test1_done),
    .cfg_error        (cfg_error),
    .fw_read_data32   (fw_read_data32),
    .fw_read_status32 (fw_read_status32)
  );

  configclk_gen #(
    .CNT_WIDTH ($bits(cfg_period_t))
  ) u_clk (
    .fw_axi_clk       (fw_axi_clk),
    .op_code_w_reset  (op_code_w_reset),
    .enable           (fw_dev_id_enable),      // Runs while the device is selected
    .configclk_period (static_cfg.fast_period),
    .clk_counter      (clk_counter),
    .configclk        (configclk)
  );

  test1_fsm u_test1 (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .op_en           (op_en),
    .sw_write24_0    (sw_write24_0),
    .static_cfg      (static_cfg),
    .clk_counter     (clk_counter),
    .configclk       (configclk),
    .chain_bit0      (chain_bit0),
    .chain_last      (chain_last),
    .chain_load      (chain_load),
    .chain_shift     (chain_shift),
    .capture_strobe  (capture_strobe),
    .loopback        (loopback),
    .asic_out        (asic_out),
    .test1_done      (test1_done),
    .cfg_error       (cfg_error)
  );

  config_shifter u_shifter (
    .fw_axi_clk  (fw_axi_clk),
    .chain_load  (chain_load),
    .chain_shift (chain_shift),
    .cfg_array   (cfg_array),
    .chain_bit0  (chain_bit0),
    .chain_last  (chain_last)
  );

  readback_capture u_capture (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .capture_strobe  (capture_strobe),
    .loopback        (loopback),
    .config_in       (asic_out.config_in),     // Loopback source
    .fw_config_out   (fw_config_out),
    .capture         (capture)
  );

endmodule

`default_nettype wire

//--- verification/ip1_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ip1_checker (
  input wire                      fw_axi_clk,
  input wire                      op_code_w_reset,
  input wire                      fw_dev_id_enable,
  input wire ip1_pkg::op_code_t   op_code,
  input wire ip1_pkg::read_word_t fw_read_data32,
  input wire ip1_pkg::asic_out_t  asic_out
);

  logic read_strobe;                        // Any read that passes the enable

  assign read_strobe = fw_dev_id_enable &&
                       (op_code.r_cfg_static || op_code.r_cfg_array || op_code.r_data_array);

  // ------------------------------
  // Properties
  // ------------------------------
  pins_quiet_after_reset: assert property (@(posedge fw_axi_clk)
    op_code_w_reset |=> (asic_out == '0))
    else $error("ASIC pins not all zero in the cycle after reset");

  // Read bus idles at zero
  read_zero_when_idle: assert property (@(posedge fw_axi_clk)
    !read_strobe |-> (fw_read_data32 == '0))
    else $error("read data not zero without a read strobe");

  clk_low_during_load: assert property (@(posedge fw_axi_clk)
    asic_out.config_load |-> !asic_out.config_clk)
    else $error("config_clk high while config_load is high");

endmodule

bind ip1_top ip1_checker u_checker (
  .fw_axi_clk       (fw_axi_clk),
  .op_code_w_reset  (op_code_w_reset),
  .fw_dev_id_enable (fw_dev_id_enable),
  .op_code          (op_code),
  .fw_read_data32   (fw_read_data32),
  .asic_out         (asic_out)
);

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 20         // Full clock period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;                        // First rising edge at half a period
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- verification/ip1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ip1_tb;

  import ip1_pkg::*;

  localparam int RUNS    = 2;                 // Loopback run, then ASIC run
  localparam int REG_OPS = 256;               // Upper bound on register strobes
  localparam int TIMEOUT = RUNS * 16 * 258 + REG_OPS * 4 + 1000;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic        fw_axi_clk;
  logic        op_code_w_reset;
  logic        fw_dev_id_enable;
  op_code_t    op_code;
  logic [23:0] sw_write24_0;
  read_word_t  fw_read_data32;
  read_word_t  fw_read_status32;
  asic_out_t   asic_out;
  logic        fw_config_out;

  // ------------------------------
  // Reference model
  // ------------------------------
  static_cfg_t m_static;
  cfg_word_t   m_array [CFG_WORDS];
  chain_t      m_capture;                     // Expected readback image
  logic [6:0]  m_sticky;                      // Sticky status bits 0..6
  logic        m_done;
  logic        m_error;

  integer seed;
  int     cycles;

  tb_clk_gen #(.PERIOD_NS(20)) u_clk_gen (.clk(fw_axi_clk));

  ip1_top u_dut (
    .fw_axi_clk       (fw_axi_clk),
    .op_code_w_reset  (op_code_w_reset),
    .fw_dev_id_enable (fw_dev_id_enable),
    .op_code          (op_code),
    .sw_write24_0     (sw_write24_0),
    .fw_read_data32   (fw_read_data32),
    .fw_read_status32 (fw_read_status32),
    .asic_out         (asic_out),
    .fw_config_out    (fw_config_out)
  );

  // ASIC stand-in returns the inverse of config_in
  always @(negedge fw_axi_clk) begin
    fw_config_out = ~asic_out.config_in;
  end

  // Run length guard
  always @(posedge fw_axi_clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first mismatch");
  endtask

  function automatic int unsigned draw_below(input int unsigned n);
    draw_below = $unsigned($random(seed)) % n;
  endfunction

  // Word 0 sits in the low bits of the chain
  function automatic chain_t array_image();
    chain_t img;
    img = '0;
    for (int i = 0; i < CFG_WORDS; i++) begin
      img[16*i +: 16] = m_array[i];
    end
    return img;
  endfunction

  function automatic read_word_t expected_read(input op_code_t op, input logic [23:0] arg);
    sw_addr_t a;
    a = arg[23:16];
    expected_read = '0;                       // Zero unless a read hits
    if (op.r_cfg_static) begin
      expected_read = {8'h00, m_static};
    end
    if (op.r_cfg_array && a < 16) begin
      expected_read = {m_array[(a + 1) % 16], m_array[a]};   // Wraps 15 to 0
    end
    if (op.r_data_array && a < 8) begin
      expected_read = m_capture[32*a +: 32];
    end
  endfunction

  function automatic read_word_t expected_status();
    read_word_t s;
    s = {25'b0, m_sticky};
    s[ST_TEST1_DONE] = m_done;
    s[ST_CFG_ERROR]  = m_error;
    return s;
  endfunction

  task automatic apply_model(input op_code_t op, input logic [23:0] arg);
    test_cfg_t tc;
    tc = test_cfg_t'(arg);
    if (op.w_execute) begin
      // Checked against the period in force before this strobe
      m_error = (tc.delay < MIN_DELAY) || (tc.delay > m_static.fast_period);
      m_done  = 1'b0;
      m_sticky[ST_EXECUTE] = 1'b1;
    end
    if (op.w_cfg_static) begin
      m_static = static_cfg_t'(arg);
      m_sticky[ST_W_STATIC] = 1'b1;
    end
    if (op.w_cfg_array) begin
      if (arg[23:16] < 8'd16) begin
        m_array[arg[19:16]] = arg[15:0];
      end
      m_sticky[ST_W_ARRAY] = 1'b1;
    end
    if (op.r_cfg_static) m_sticky[ST_R_STATIC] = 1'b1;
    if (op.r_cfg_array)  m_sticky[ST_R_ARRAY]  = 1'b1;
    if (op.r_data_array) m_sticky[ST_R_DATA]   = 1'b1;
    if (op.w_status_clear) begin
      m_sticky = '0;                          // Clear wins
    end
  endtask

  task automatic check_status();
    @(negedge fw_axi_clk);                    // Let the flag copies settle
    assert (fw_read_status32 == expected_status())
      else report_mismatch("status word", fw_read_status32, expected_status());
  endtask

  // One strobe cycle, read data checked mid-cycle, then status
  task automatic do_op(input op_code_t op, input logic [23:0] arg, input logic en);
    op_code_t   gated;
    read_word_t exp;
    gated = en ? op : '0;
    exp   = expected_read(gated, arg);
    @(negedge fw_axi_clk);
    fw_dev_id_enable = en;
    op_code          = op;
    sw_write24_0     = arg;
    #5;
    assert (fw_read_data32 == exp)
      else report_mismatch("read data", fw_read_data32, exp);
    apply_model(gated, arg);
    @(negedge fw_axi_clk);
    op_code          = '0;
    fw_dev_id_enable = 1'b1;
    check_status();
  endtask

  // ------------------------------
  // Test phases
  // ------------------------------
  task automatic check_static_regs();
    op_code_t    op;
    logic [23:0] arg;
    for (int i = 0; i < 24; i++) begin
      arg = 24'($random(seed));
      op  = '0;
      op.w_cfg_static = 1'b1;
      do_op(op, arg, draw_below(5) != 0);     // Device off now and then
      op = '0;
      op.r_cfg_static = 1'b1;
      do_op(op, 24'h0, draw_below(5) != 0);
    end
  endtask

  task automatic check_array_pairs();
    op_code_t    op;
    logic [23:0] arg;
    op = '0;
    op.w_cfg_array = 1'b1;
    for (int i = 0; i < 24; i++) begin
      arg = {3'b000, 5'(draw_below(32)), 16'($random(seed))};   // Half out of range
      do_op(op, arg, 1'b1);
    end
    op = '0;
    op.r_cfg_array = 1'b1;
    for (int a = 0; a < 20; a++) begin
      do_op(op, {8'(a), 16'h0}, 1'b1);        // Covers wrap and the zero range
    end
  endtask

  task automatic check_sticky_status();
    op_code_t    op;
    logic [23:0] arg;
    logic [7:0]  r;
    op = '0;
    op.w_status_clear = 1'b1;
    do_op(op, 24'h0, 1'b1);
    for (int i = 0; i < 30; i++) begin
      r  = 8'(draw_below(256));
      op = '0;
      op.w_cfg_static   = r[0];
      op.w_cfg_array    = r[1];
      op.w_status_clear = (r[4:2] == 3'b000);
      case (r[6:5])                           // At most one read
        2'd1: op.r_cfg_static = 1'b1;
        2'd2: op.r_cfg_array  = 1'b1;
        2'd3: op.r_data_array = 1'b1;
        default: ;
      endcase
      arg = 24'($random(seed));
      arg[23:21] = 3'b000;
      do_op(op, arg, 1'b1);
    end
  endtask

  task automatic run_test1(input logic loop);
    cfg_period_t period;
    cfg_period_t delay;
    cfg_period_t sample;
    logic        mask;
    logic        saw_reset_low;
    logic        clk_prev;
    int          load_low;
    int          clk_rises;
    int          exp_load_low;
    int          exp_rises;
    static_cfg_t sc;
    test_cfg_t   tc;
    op_code_t    op;
    chain_t      image;
    asic_out_t   exp_pins;
    period = cfg_period_t'(8 + draw_below(8));
    delay  = cfg_period_t'(3 + draw_below(period - 2));       // 3 .. period
    sample = cfg_period_t'(draw_below(delay));                 // Before the shift
    mask   = (draw_below(4) == 0);
    sc = '0;
    sc.super_pixel_sel = draw_below(2) != 0;
    sc.fast_period     = period;
    op = '0;
    op.w_cfg_static = 1'b1;
    do_op(op, sc, 1'b1);
    op = '0;
    op.w_cfg_array = 1'b1;
    for (int w = 0; w < CFG_WORDS; w++) begin
      do_op(op, {8'(w), 16'($random(seed))}, 1'b1);
    end
    tc = '0;
    tc.mask_reset_not = mask;
    tc.loopback       = loop;
    tc.test_number    = TEST1_NUMBER;
    tc.sample         = sample;
    tc.delay          = delay;
    op = '0;
    op.w_execute = 1'b1;
    do_op(op, tc, 1'b1);
    image         = array_image();
    saw_reset_low = 1'b0;
    clk_prev      = 1'b0;
    load_low      = 0;
    clk_rises     = 0;
    // 255 full config-clock cycles, then the last one up to the shift phase
    exp_load_low  = 255 * (period + 1) + delay + 1;
    exp_rises     = 255 + ((delay > (period >> 1)) ? 1 : 0);
    while (!fw_read_status32[ST_TEST1_DONE]) begin
      @(negedge fw_axi_clk);
      if (!asic_out.reset_not) saw_reset_low = 1'b1;
      if (!asic_out.config_load) load_low++;
      if (asic_out.config_clk && !clk_prev) clk_rises++;    // One rise per config cycle
      clk_prev = asic_out.config_clk;
      assert (asic_out.super_pixel_sel == sc.super_pixel_sel)
        else report_mismatch("super_pixel_sel pin", asic_out.super_pixel_sel,
                             sc.super_pixel_sel);
    end
    m_done    = 1'b1;
    m_capture = loop ? image : ~image;       // Stand-in inverts each bit
    assert (saw_reset_low == !mask)
      else report_mismatch("reset pulse seen", saw_reset_low, !mask);
    assert (load_low == exp_load_low)
      else report_mismatch("cycles with config_load low", load_low, exp_load_low);
    assert (clk_rises == exp_rises)
      else report_mismatch("config_clk pulses while shifting", clk_rises, exp_rises);
    check_status();
    exp_pins                 = '0;
    exp_pins.super_pixel_sel = sc.super_pixel_sel;
    exp_pins.reset_not       = 1'b1;
    exp_pins.config_load     = 1'b1;
    assert (asic_out == exp_pins)
      else report_mismatch("ASIC pins in done", asic_out, exp_pins);
    op = '0;
    op.r_data_array = 1'b1;
    for (int a = 0; a < 11; a++) begin
      do_op(op, {8'(a), 16'h0}, 1'b1);       // 8 and up read zero
    end
  endtask

  task automatic check_delay_errors();
    cfg_period_t p;
    test_cfg_t   tc;
    op_code_t    op;
    p  = m_static.fast_period;
    op = '0;
    op.w_execute = 1'b1;
    tc = '0;
    tc.test_number = 4'd2;                   // Keeps test1 idle
    tc.delay = cfg_period_t'(p + 1 + draw_below(8));
    do_op(op, tc, 1'b1);
    assert (fw_read_status32[ST_CFG_ERROR])
      else report_mismatch("error bit, delay above period", fw_read_status32, 32'h80000000);
    assert (asic_out == '0)
      else report_mismatch("ASIC pins with test1 off", asic_out, 32'h0);
    tc.delay = cfg_period_t'(draw_below(3));
    do_op(op, tc, 1'b1);
    assert (fw_read_status32[ST_CFG_ERROR])
      else report_mismatch("error bit, delay below 3", fw_read_status32, 32'h80000000);
    tc.delay = cfg_period_t'(3 + draw_below(p - 2));
    do_op(op, tc, 1'b1);
    assert (!fw_read_status32[ST_CFG_ERROR])
      else report_mismatch("error bit after valid execute", fw_read_status32, 32'h0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed             = 92438;
    cycles           = 0;
    op_code_w_reset  = 1'b1;
    fw_dev_id_enable = 1'b0;
    op_code          = '0;
    sw_write24_0     = '0;
    fw_config_out    = 1'b0;
    m_static  = '0;
    m_capture = '0;
    m_sticky  = 7'b0000001;                  // Reset bit only
    m_done    = 1'b0;
    m_error   = 1'b0;
    for (int i = 0; i < CFG_WORDS; i++) begin
      m_array[i] = '0;
    end
    repeat (10) @(negedge fw_axi_clk);
    op_code_w_reset  = 1'b0;
    fw_dev_id_enable = 1'b1;
    check_status();
    assert (asic_out == '0)
      else report_mismatch("ASIC pins after reset", asic_out, 32'h0);
    check_static_regs();
    check_array_pairs();
    check_sticky_status();
    run_test1(1'b1);                         // Loopback
    run_test1(1'b0);                         // Through the ASIC stand-in
    check_delay_errors();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
common/ip1_pkg.sv
configclk/configclk_gen.sv
test1/config_shifter.sv
test1/readback_capture.sv
test1/test1_fsm.sv
design/sw_cmd_regs.sv
design/sw_readout.sv
design/ip1_top.sv
verification/ip1_checker.sv
verification/tb_clk_gen.sv
verification/ip1_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
TOP       := ip1_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
